// File: io_subsys.f
src/io_pkg.sv
src/io_bus_if.sv
src/io_led.sv
src/io_uart_out.sv
src/io_frc.sv
src/io_subsys.sv
sim/io_subsys_chk.sv
sim/io_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the io_subsys testbench with verilator, run it, judge by the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f io_subsys.f --top-module io_subsys_tb -o io_subsys_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/io_subsys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: sim/io_subsys_chk.sv
`timescale 1ns/1ps

module io_subsys_chk
	import io_pkg::*;
	(
	input i_clk,
	input i_rst_n,
	input i_io_we,
	input [IO_AW-1:0] i_io_wadr,
	input [IO_DW-1:0] i_io_wdata,
	input i_io_radr_en,
	input [IO_DW-1:0] i_io_rdata,
	input i_uart_we,
	input i_uart_full,
	input i_frc_int
	);

// queue is never empty right after a char write
assert property (@(posedge i_clk) disable iff (!i_rst_n)
	i_io_we && i_io_wadr == IO_ADR_UART_CHAR |=> i_uart_we == !i_uart_full)
	else $error("o_uart_we does not follow i_uart_full after a char write");

// read data only in the cycle after a request
assert property (@(posedge i_clk) disable iff (!i_rst_n)
	!$past(i_io_radr_en) |-> i_io_rdata == '0)
	else $error("o_io_rdata nonzero without a read request one cycle before");

// clearing mtie drops the interrupt at once
assert property (@(posedge i_clk) disable iff (!i_rst_n)
	i_io_we && i_io_wadr == IO_ADR_FRC_CTRL && !i_io_wdata[FRC_CTRL_MTIE] |=> !i_frc_int)
	else $error("o_frc_int still high after mtie was cleared");

endmodule

bind io_subsys io_subsys_chk chk_i (
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_io_we(i_io_we),
	.i_io_wadr(i_io_wadr),
	.i_io_wdata(i_io_wdata),
	.i_io_radr_en(i_io_radr_en),
	.i_io_rdata(o_io_rdata),
	.i_uart_we(o_uart_we),
	.i_uart_full(i_uart_full),
	.i_frc_int(o_frc_int)
	);

// File: sim/io_subsys_input.txt
# cmd adr data expect mask, hex; W expect bit 0 set marks a char that must reach the uart
# R checks read data under mask, I checks o_frc_int, F sets i_uart_full, N idles data cycles, T ends test
W 3F00 00000A5C 0 0
R 3F00 0 00000A5C FFFFFFFF
R 3F05 0 0 FFFFFFFF
T 0 1 0 0
W 3F01 41 1 0
W 3F01 42 1 0
W 3F01 43 1 0
N 0 8 0 0
T 0 2 0 0
F 0 1 0 0
W 3F01 61 1 0
W 3F01 62 1 0
W 3F01 63 1 0
W 3F01 64 1 0
W 3F01 65 0 0
R 3F02 0 5 FFFFFFFF
R 3F02 0 1 FFFFFFFF
F 0 0 0 0
N 0 8 0 0
R 3F02 0 2 FFFFFFFF
T 0 3 0 0
W 3F10 12345600 0 0
N 0 2 0 0
R 3F10 0 12345600 FFFFFF00
T 0 4 0 0
W 3F11 1000 0 0
W 3F10 FF0 0 0
W 3F12 1 0 0
N 0 40 0 0
I 0 0 1 1
W 3F12 0 0 0
I 0 0 0 1
R 3F12 0 0 FFFFFFFF
T 0 5 0 0

// File: sim/io_subsys_tb.sv
`timescale 1ns/1ps

module io_subsys_tb
	import io_pkg::*;
	();

localparam int UART_FIFO_DEPTH = 4;

logic i_clk;
logic i_rst_n;
logic i_io_we;
logic [IO_AW-1:0] i_io_wadr;
logic [IO_DW-1:0] i_io_wdata;
logic [IO_AW-1:0] i_io_radr;
logic i_io_radr_en;
logic [IO_DW-1:0] o_io_rdata;
logic [2:0] o_rgb_led;
logic [2:0] o_rgb_led1;
logic [2:0] o_rgb_led2;
logic [2:0] o_rgb_led3;
logic [7:0] o_uart_char;
logic o_uart_we;
logic i_uart_full;
logic o_frc_int;

logic [7:0] seen_chars[$]; // taken by the uart side
logic [7:0] exp_chars[$]; // written and not dropped
logic [7:0] q_cmd[$];
logic [31:0] q_adr[$];
logic [31:0] q_dat[$];
logic [31:0] q_exp[$];
logic [31:0] q_msk[$];
int errors = 0;
int test_errors = 0;
int tests = 0;
int limit_cycles = 0;

io_subsys #(.UART_FIFO_DEPTH(UART_FIFO_DEPTH)) io_subsys_i (.*);

always #2 i_clk = ~i_clk;

always @(posedge i_clk) begin
	if (i_rst_n && o_uart_we)
		seen_chars.push_back(o_uart_char);
end

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expv);
	if (got !== expv) begin
		errors++;
		test_errors++;
		$display("mismatch %s: got %h, expected %h", name, got, expv);
	end
endtask

task automatic compare_chars();
	check_val("uart char count", seen_chars.size(), exp_chars.size());
	while (seen_chars.size() > 0 && exp_chars.size() > 0)
		check_val("o_uart_char", {24'd0, seen_chars.pop_front()},
			{24'd0, exp_chars.pop_front()});
	seen_chars.delete();
	exp_chars.delete();
endtask

task automatic run_line(input logic [7:0] cmd, input logic [31:0] adr, input logic [31:0] dat,
	input logic [31:0] expv, input logic [31:0] msk);
	case (cmd)
		"W": begin
			i_io_we = 1'b1;
			i_io_wadr = adr[IO_AW-1:0];
			i_io_wdata = dat;
			@(negedge i_clk);
			i_io_we = 1'b0;
			if (adr[IO_AW-1:0] == IO_ADR_UART_CHAR && expv[0])
				exp_chars.push_back(dat[7:0]);
			if (adr[IO_AW-1:0] == IO_ADR_LED) begin // each led is a 3-bit slice
				check_val("o_rgb_led", {29'd0, o_rgb_led}, {29'd0, dat[2:0]});
				check_val("o_rgb_led1", {29'd0, o_rgb_led1}, {29'd0, dat[5:3]});
				check_val("o_rgb_led2", {29'd0, o_rgb_led2}, {29'd0, dat[8:6]});
				check_val("o_rgb_led3", {29'd0, o_rgb_led3}, {29'd0, dat[11:9]});
			end
		end
		"R": begin
			i_io_radr = adr[IO_AW-1:0];
			i_io_radr_en = 1'b1;
			@(negedge i_clk); // data registered at the edge in between
			i_io_radr_en = 1'b0;
			check_val("o_io_rdata", o_io_rdata & msk, expv & msk);
		end
		"F": i_uart_full = dat[0];
		"N": repeat (dat) @(negedge i_clk);
		"I": check_val("o_frc_int", {31'd0, o_frc_int} & msk, expv & msk);
		"T": begin
			compare_chars();
			tests++;
			$display("test %0d finished with %0d errors", dat, test_errors);
			test_errors = 0;
		end
		default: begin
			errors++;
			$display("unknown command %c in the stimulus file", cmd);
		end
	endcase
	repeat ($urandom_range(3)) @(negedge i_clk); // random idle gap
endtask

initial begin
	int fd;
	int k;
	string line;
	logic [7:0] cmd;
	logic [31:0] adr;
	logic [31:0] dat;
	logic [31:0] expv;
	logic [31:0] msk;
	void'($urandom(84328));
	i_clk = 1'b0;
	i_rst_n = 1'b0;
	i_io_we = 1'b0;
	i_io_wadr = '0;
	i_io_wdata = '0;
	i_io_radr = '0;
	i_io_radr_en = 1'b0;
	i_uart_full = 1'b0;
	fd = $fopen("sim/io_subsys_input.txt", "r");
	if (fd == 0) begin
		errors++;
		$display("stimulus file sim/io_subsys_input.txt could not be opened");
	end else begin
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin // skip column notes
				if ($sscanf(line, "%c %h %h %h %h", cmd, adr, dat, expv, msk) == 5) begin
					q_cmd.push_back(cmd);
					q_adr.push_back(adr);
					q_dat.push_back(dat);
					q_exp.push_back(expv);
					q_msk.push_back(msk);
				end
			end
		end
		$fclose(fd);
	end
	limit_cycles = q_cmd.size() * 40 + 200;
	repeat (8) @(posedge i_clk);
	@(negedge i_clk);
	i_rst_n = 1'b1;
	for (k = 0; k < q_cmd.size(); k++)
		run_line(q_cmd[k], q_adr[k], q_dat[k], q_exp[k], q_msk[k]);
	$display("%0d tests run, %0d errors", tests, errors);
	if (errors == 0 && tests > 0)
		$display("Test completed successfully");
	else
		$display("Test failed");
	$finish;
end

// watchdog sized from the number of stimulus lines
initial begin
	wait (limit_cycles != 0);
	repeat (limit_cycles) @(posedge i_clk);
	$display("timeout, stimulus did not finish within %0d cycles", limit_cycles);
	$display("Test failed");
	$finish;
end

endmodule

// File: src/io_bus_if.sv
`timescale 1ns/1ps

interface io_bus_if
	import io_pkg::*;
	();

	logic we; // write strobe
	logic [IO_AW-1:0] wadr; // word write address
	logic [IO_DW-1:0] wdata;
	logic [IO_AW-1:0] radr; // word read address
	logic radr_en; // read request, data follows next cycle

	modport host (
		output we,
		output wadr,
		output wdata,
		output radr,
		output radr_en
	);

	modport periph (
		input we,
		input wadr,
		input wdata,
		input radr,
		input radr_en
	);

endinterface

// File: src/io_frc.sv
`timescale 1ns/1ps

module io_frc
	import io_pkg::*;
	(
	input i_clk,
	input i_rst_n,
	io_bus_if.periph bus,
	input [IO_DW-1:0] i_rdata_in,
	output [IO_DW-1:0] o_rdata,
	output o_frc_int
	);

logic [IO_DW-1:0] cnt; // free running, wraps
logic [IO_DW-1:0] cmp;
logic mtie;
logic [IO_DW-1:0] ctrl_word;
logic [IO_DW-1:0] rd_sel;
logic [IO_DW-1:0] rd_word;
logic wr_cnt;
logic wr_cmp;
logic wr_ctrl;

assign wr_cnt  = bus.we && (bus.wadr == IO_ADR_FRC_CNT);
assign wr_cmp  = bus.we && (bus.wadr == IO_ADR_FRC_CMP);
assign wr_ctrl = bus.we && (bus.wadr == IO_ADR_FRC_CTRL);

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n)
		cnt <= '0;
	else if (wr_cnt)
		cnt <= bus.wdata; // software load
	else
		cnt <= cnt + 32'd1;
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		cmp  <= '1; // never matches before software sets it
		mtie <= 1'b0;
	end else begin
		if (wr_cmp)
			cmp <= bus.wdata;
		if (wr_ctrl)
			mtie <= bus.wdata[FRC_CTRL_MTIE];
	end
end

always_comb begin
	ctrl_word = '0;
	ctrl_word[FRC_CTRL_MTIE] = mtie;
end

always_comb begin
	rd_sel = '0;
	if (bus.radr_en) begin
		case (bus.radr)
			IO_ADR_FRC_CNT:  rd_sel = cnt;
			IO_ADR_FRC_CMP:  rd_sel = cmp;
			IO_ADR_FRC_CTRL: rd_sel = ctrl_word;
			default:         rd_sel = '0; // not ours
		endcase
	end
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n)
		rd_word <= '0;
	else
		rd_word <= rd_sel;
end

assign o_rdata = i_rdata_in | rd_word;

// level interrupt, held until cmp raised, cnt reloaded or mtie cleared
assign o_frc_int = mtie && (cnt >= cmp);

endmodule

// File: src/io_led.sv
`timescale 1ns/1ps

module io_led
	import io_pkg::*;
	(
	input i_clk,
	input i_rst_n,
	io_bus_if.periph bus,
	input [IO_DW-1:0] i_rdata_in,
	output [IO_DW-1:0] o_rdata,
	output [2:0] o_rgb_led,
	output [2:0] o_rgb_led1,
	output [2:0] o_rgb_led2,
	output [2:0] o_rgb_led3
	);

logic [11:0] led_reg; // 3 bits per led
logic [IO_DW-1:0] rd_word;
logic wr_hit;
logic rd_hit;

assign wr_hit = bus.we && (bus.wadr == IO_ADR_LED);
assign rd_hit = bus.radr_en && (bus.radr == IO_ADR_LED);

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		led_reg <= 12'd0;
	end else if (wr_hit) begin
		led_reg <= bus.wdata[11:0];
	end
end

// read word only lives for the cycle after the request
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		rd_word <= '0;
	end else if (rd_hit) begin
		rd_word <= {{(IO_DW-12){1'b0}}, led_reg};
	end else begin
		rd_word <= '0;
	end
end

assign o_rdata = i_rdata_in | rd_word; // join the read chain

assign o_rgb_led  = led_reg[2:0];
assign o_rgb_led1 = led_reg[5:3];
assign o_rgb_led2 = led_reg[8:6];
assign o_rgb_led3 = led_reg[11:9];

endmodule

// File: src/io_pkg.sv
package io_pkg;

	// cpu i/o bus geometry, word address covers byte address bits 15:2
	localparam int IO_AW = 14;
	localparam int IO_DW = 32;

	// word addresses of the peripheral registers
	localparam logic [IO_AW-1:0] IO_ADR_LED       = 14'h3F00; // rgb led pattern
	localparam logic [IO_AW-1:0] IO_ADR_UART_CHAR = 14'h3F01; // char push, write only
	localparam logic [IO_AW-1:0] IO_ADR_UART_STAT = 14'h3F02; // queue status
	localparam logic [IO_AW-1:0] IO_ADR_FRC_CNT   = 14'h3F10; // counter value
	localparam logic [IO_AW-1:0] IO_ADR_FRC_CMP   = 14'h3F11; // compare value
	localparam logic [IO_AW-1:0] IO_ADR_FRC_CTRL  = 14'h3F12; // control

	// uart status word bits
	localparam int UART_STAT_FULL  = 0;
	localparam int UART_STAT_EMPTY = 1;
	localparam int UART_STAT_OVR   = 2; // sticky, cleared by status read

	// frc control word bits
	localparam int FRC_CTRL_MTIE = 0; // timer interrupt enable

endpackage

// File: src/io_subsys.sv
`timescale 1ns/1ps

module io_subsys
	import io_pkg::*;
	#(parameter int UART_FIFO_DEPTH = 4)
	(
	input i_clk,
	input i_rst_n,
	input i_io_we,
	input [IO_AW-1:0] i_io_wadr,
	input [IO_DW-1:0] i_io_wdata,
	input [IO_AW-1:0] i_io_radr,
	input i_io_radr_en,
	output [IO_DW-1:0] o_io_rdata,
	output [2:0] o_rgb_led,
	output [2:0] o_rgb_led1,
	output [2:0] o_rgb_led2,
	output [2:0] o_rgb_led3,
	output [7:0] o_uart_char,
	output o_uart_we,
	input i_uart_full,
	output o_frc_int
	);

// read chain: led -> uart -> frc -> o_io_rdata
logic [IO_DW-1:0] rdata_led;
logic [IO_DW-1:0] rdata_uart;

io_bus_if io_bus ();

// host side of the bus comes straight from the cpu ports
assign io_bus.we      = i_io_we;
assign io_bus.wadr    = i_io_wadr;
assign io_bus.wdata   = i_io_wdata;
assign io_bus.radr    = i_io_radr;
assign io_bus.radr_en = i_io_radr_en;

io_led io_led (
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.bus(io_bus.periph),
	.i_rdata_in({IO_DW{1'b0}}), // head of the chain
	.o_rdata(rdata_led),
	.o_rgb_led(o_rgb_led),
	.o_rgb_led1(o_rgb_led1),
	.o_rgb_led2(o_rgb_led2),
	.o_rgb_led3(o_rgb_led3)
	);

io_uart_out #(.UART_FIFO_DEPTH(UART_FIFO_DEPTH)) io_uart_out (
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.bus(io_bus.periph),
	.i_rdata_in(rdata_led),
	.o_rdata(rdata_uart),
	.o_uart_char(o_uart_char),
	.o_uart_we(o_uart_we),
	.i_uart_full(i_uart_full)
	);

io_frc io_frc (
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.bus(io_bus.periph),
	.i_rdata_in(rdata_uart),
	.o_rdata(o_io_rdata), // end of the chain
	.o_frc_int(o_frc_int)
	);

endmodule

// File: src/io_uart_out.sv
`timescale 1ns/1ps

module io_uart_out
	import io_pkg::*;
	#(parameter int UART_FIFO_DEPTH = 4)
	(
	input i_clk,
	input i_rst_n,
	io_bus_if.periph bus,
	input [IO_DW-1:0] i_rdata_in,
	output [IO_DW-1:0] o_rdata,
	output [7:0] o_uart_char,
	output o_uart_we,
	input i_uart_full
	);

localparam int PW = $clog2(UART_FIFO_DEPTH);
localparam logic [PW:0] FULL_CNT = (PW+1)'(UART_FIFO_DEPTH);

logic [7:0] fifo_mem [0:UART_FIFO_DEPTH-1];
logic [PW-1:0] wptr;
logic [PW-1:0] rptr;
logic [PW:0] count; // occupancy, one bit wider than the pointers
logic ovr; // sticky overrun
logic full;
logic empty;
logic wr_char;
logic rd_stat;
logic push;
logic pop;
logic [IO_DW-1:0] stat_word;
logic [IO_DW-1:0] rd_word;

assign full    = (count == FULL_CNT);
assign empty   = (count == '0);
assign wr_char = bus.we && (bus.wadr == IO_ADR_UART_CHAR);
assign rd_stat = bus.radr_en && (bus.radr == IO_ADR_UART_STAT);
assign push    = wr_char && !full; // dropped when full
assign pop     = !empty && !i_uart_full; // consumer takes one per cycle

always_ff @(posedge i_clk) begin
	if (push)
		fifo_mem[wptr] <= bus.wdata[7:0];
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		wptr  <= '0;
		rptr  <= '0;
		count <= '0;
	end else begin
		if (push)
			wptr <= wptr + PW'(1);
		if (pop)
			rptr <= rptr + PW'(1);
		count <= count + {{PW{1'b0}}, push} - {{PW{1'b0}}, pop};
	end
end

// a drop in the same cycle as a status read stays visible next time
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n)
		ovr <= 1'b0;
	else if (wr_char && full)
		ovr <= 1'b1;
	else if (rd_stat)
		ovr <= 1'b0;
end

always_comb begin
	stat_word = '0;
	stat_word[UART_STAT_FULL]  = full;
	stat_word[UART_STAT_EMPTY] = empty;
	stat_word[UART_STAT_OVR]   = ovr;
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n)
		rd_word <= '0;
	else
		rd_word <= rd_stat ? stat_word : '0;
end

assign o_rdata     = i_rdata_in | rd_word;
assign o_uart_char = fifo_mem[rptr]; // head of queue
assign o_uart_we   = pop;

endmodule
